//--- Bender.yml
package:
  name: lc3b_fetch

sources:
  - verilog/lc3b_fetch_pkg.sv
  - verilog/pc_unit.sv
  - verilog/wb_fetch_port.sv
  - verilog/ir_unit.sv
  - verilog/if_datapath.sv
  - target: test
    files:
      - verification/tb_wb_memory.sv
      - verification/if_datapath_checker.sv
      - verification/tb_if_datapath.sv

//--- flist.f
verilog/lc3b_fetch_pkg.sv
verilog/pc_unit.sv
verilog/wb_fetch_port.sv
verilog/ir_unit.sv
verilog/if_datapath.sv
verification/tb_wb_memory.sv
verification/if_datapath_checker.sv
verification/tb_if_datapath.sv

//--- verification/if_datapath_checker.sv
`timescale 1ns/1ns

module if_datapath_checker
    import lc3b_fetch_pkg::*;
(
    input logic     clk,
    input logic     if_stall_count_reset,
    input logic     wb_cyc,
    input logic     wb_stb,
    input logic     wb_we,
    input logic     wb_ack,
    input lc3b_word wb_adr
);

    // ##################################################
    // Wishbone classic read master
    // ##################################################

    stb_needs_cyc: assert property (@(posedge clk) disable iff (if_stall_count_reset)
        wb_stb |-> wb_cyc)
        else $error("wb_stb high without wb_cyc");

    req_held_until_ack: assert property (@(posedge clk) disable iff (if_stall_count_reset)
        (wb_stb && !wb_ack) |=> (wb_stb && $stable(wb_adr)))
        else $error("wb_stb or wb_adr changed before wb_ack");

    never_writes: assert property (@(posedge clk) disable iff (if_stall_count_reset)
        !wb_we)
        else $error("wb_we raised by the fetch port");

    // Bus is quiet right after reset
    idle_after_reset: assert property (@(posedge clk)
        if_stall_count_reset |=> !wb_cyc)
        else $error("wb_cyc high in the cycle after reset");

endmodule : if_datapath_checker

bind if_datapath if_datapath_checker i_checker (
    .clk                  (clk),
    .if_stall_count_reset (if_stall_count_reset),
    .wb_cyc               (wb_cyc),
    .wb_stb               (wb_stb),
    .wb_we                (wb_we),
    .wb_ack               (wb_ack),
    .wb_adr               (wb_adr)
);

//--- verification/tb_if_datapath.sv
`timescale 1ns/1ns

module tb_if_datapath
    import lc3b_fetch_pkg::*;
();

    localparam int       NUM_TESTS   = 5;
    localparam int       CYCLE_LIMIT = 40 * NUM_TESTS;
    localparam lc3b_word MEM_KEY     = 16'h5A3C;

    logic       clk;
    logic       if_stall_count_reset;
    logic       br_en, trap_en, jmp_jsr_en, b11, stall, flush;
    pcmux_sel_t pcmux_sel;
    lc3b_word   pc_br_in, sr1_data_in, trap_mem;
    logic       wb_cyc, wb_stb, wb_we, wb_ack;
    lc3b_word   wb_adr, wb_dat_i;
    lc3b_word   pc_out, instruction, if_stall_count;
    lc3b_reg    src1, src2, dest;

    int       checks = 0;
    int       errors = 0;
    int       cycle_count = 0;
    lc3b_word exp_pc;
    lc3b_word exp_instr;

    if_datapath i_dut (.*);

    tb_wb_memory i_memory (.clk, .wb_cyc, .wb_stb, .wb_we, .wb_adr,
                           .wb_dat_o(wb_dat_i), .wb_ack);

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > CYCLE_LIMIT) begin
            $display("Timeout, the tests did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Checks failed");
            $finish;
        end
    end

    // ##################################################
    // Helpers
    // ##################################################

    function automatic lc3b_word mem_word(input lc3b_word adr);
        return adr ^ MEM_KEY;
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic compare_word(input string name, input lc3b_word got, input lc3b_word expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("[FAIL] %s = %h, expected %h", name, got, expected);
        end
    endtask

    task automatic compare_reg(input string name, input lc3b_reg got, input lc3b_reg expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("[FAIL] %s = %h, expected %h", name, got, expected);
        end
    endtask

    task automatic compare_instr(input lc3b_instr got, input lc3b_instr expected);
        string detail;
        checks++;
        if (got !== expected) begin
            errors++;
            detail = $sformatf("opcode %h/%h dest %h/%h src1 %h/%h",
                               got.fields.opcode, expected.fields.opcode,
                               got.fields.dest, expected.fields.dest,
                               got.fields.src1, expected.fields.src1);
            detail = {detail, $sformatf(" mode %h/%h pad %h/%h src2 %h/%h",
                                        got.fields.mode, expected.fields.mode,
                                        got.fields.pad, expected.fields.pad,
                                        got.fields.src2, expected.fields.src2)};
            $display("[FAIL] instruction = %h, expected %h (%s)",
                     got.raw, expected.raw, detail);
        end
    endtask

    // Returns 2 ns after the edge that buffers the word
    task automatic wait_ack(input lc3b_word adr);
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!(wb_cyc && wb_ack) && n < 8);
        if (wb_cyc && wb_ack) begin
            compare_word("wb_adr", wb_adr, adr);
        end else begin
            errors++;
            $display("No Wishbone ack within 8 cycles for the read at %h", adr);
        end
        next_cycle();
    endtask

    task automatic fetch_and_check(input lc3b_word adr);
        lc3b_word word;
        word = mem_word(adr);
        wait_ack(adr);
        // Buffered word is taken at the next edge
        next_cycle();
        compare_instr(instruction, word);
        compare_reg("dest", dest, word[11:9]);
        compare_reg("src1", src1, word[8:6]);
        compare_reg("src2", src2, word[2:0]);
        compare_word("pc_out", pc_out, adr + 16'd2);
        exp_instr = word;
        exp_pc    = adr + 16'd2;
    endtask

    // ctrl is {br_en, trap_en, jmp_jsr_en, b11}
    task automatic redirect_and_fetch(input logic [3:0] ctrl, input lc3b_word target);
        int n;
        {br_en, trap_en, jmp_jsr_en, b11} = ctrl;
        next_cycle();
        {br_en, trap_en, jmp_jsr_en, b11} = 4'b0000;
        compare_word("pc_out", pc_out, target);
        // A read in flight at the redirect finishes and is dropped
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (wb_cyc && n < 8);
        if (wb_cyc) begin
            errors++;
            $display("Wishbone cycle still open 8 cycles after the redirect to %h", target);
        end
        compare_word("instruction", instruction, exp_instr);
        fetch_and_check(target);
    endtask

    task automatic end_test(input string name, input int start);
        $display("%s finished with %0d errors", name, errors - start);
    endtask

    // ##################################################
    // Tests
    // ##################################################

    task automatic after_reset();
        int start;
        start = errors;
        repeat (5) @(posedge clk);
        #2;
        if_stall_count_reset = 1'b0;
        compare_word("pc_out", pc_out, 16'h0000);
        compare_instr(instruction, NOP_WORD);
        compare_word("if_stall_count", if_stall_count, 16'h0000);
        exp_pc    = 16'h0000;
        exp_instr = NOP_WORD;
        end_test("after_reset", start);
    endtask

    task automatic sequential_fetch();
        int start;
        start = errors;
        repeat (6) fetch_and_check(exp_pc);
        end_test("sequential_fetch", start);
    endtask

    task automatic redirect_priority();
        int start;
        start       = errors;
        pc_br_in    = 16'h1200;
        trap_mem    = 16'h0400;
        sr1_data_in = 16'h3000;
        // Branch beats trap
        redirect_and_fetch(4'b1100, 16'h1200);
        // Trap lands while the next read is on the bus
        next_cycle();
        redirect_and_fetch(4'b0100, 16'h0400);
        pc_br_in = 16'h2000;
        // JMP drops the word sitting in the buffer
        wait_ack(exp_pc);
        redirect_and_fetch(4'b0011, 16'h2000);
        redirect_and_fetch(4'b0010, 16'h3000);
        end_test("redirect_priority", start);
    endtask

    task automatic stall_and_flush();
        int       start;
        lc3b_word adr;
        start = errors;
        adr   = exp_pc;
        wait_ack(adr);
        stall = 1'b1;
        repeat (4) begin
            next_cycle();
            compare_word("pc_out", pc_out, adr);
            compare_word("instruction", instruction, exp_instr);
            checks++;
            if (wb_cyc !== 1'b0) begin
                errors++;
                $display("[FAIL] wb_cyc = %h, expected 0 with a full buffer under stall", wb_cyc);
            end
        end
        // Word is taken on release, but flush puts a NOP in its place
        stall = 1'b0;
        flush = 1'b1;
        next_cycle();
        flush = 1'b0;
        compare_instr(instruction, NOP_WORD);
        compare_word("pc_out", pc_out, adr + 16'd2);
        exp_instr = NOP_WORD;
        fetch_and_check(adr + 16'd2);
        end_test("stall_and_flush", start);
    endtask

    task automatic stall_counter();
        int       start;
        int       k;
        lc3b_word count;
        logic     full;
        start = errors;
        if_stall_count_reset = 1'b1;
        next_cycle();
        if_stall_count_reset = 1'b0;
        count = 16'h0000;
        full  = 1'b0;
        for (k = 0; k < 24; k++) begin
            stall = (k >= 8 && k < 13);
            @(negedge clk);
            if (!full && !stall) begin
                count++;
            end
            // Buffer fills on the ack edge and empties when taken
            if (wb_cyc && wb_ack) begin
                full = 1'b1;
            end else if (full && !stall) begin
                full = 1'b0;
            end
            next_cycle();
        end
        stall = 1'b0;
        compare_word("if_stall_count", if_stall_count, count);
        if_stall_count_reset = 1'b1;
        next_cycle();
        if_stall_count_reset = 1'b0;
        compare_word("if_stall_count", if_stall_count, 16'h0000);
        end_test("stall_counter", start);
    endtask

    initial begin
        clk                  = 1'b0;
        if_stall_count_reset = 1'b1;
        {br_en, trap_en, jmp_jsr_en, b11} = 4'b0000;
        stall                = 1'b0;
        flush                = 1'b0;
        pcmux_sel            = pc_plus2;
        pc_br_in             = 16'h0000;
        sr1_data_in          = 16'h0000;
        trap_mem             = 16'h0000;
        after_reset();
        sequential_fetch();
        redirect_priority();
        stall_and_flush();
        stall_counter();
        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule : tb_if_datapath

//--- verification/tb_wb_memory.sv
`timescale 1ns/1ns

module tb_wb_memory
    import lc3b_fetch_pkg::*;
(
    input  logic     clk,
    input  logic     wb_cyc,
    input  logic     wb_stb,
    input  logic     wb_we,
    input  lc3b_word wb_adr,
    output lc3b_word wb_dat_o,
    output logic     wb_ack
);

    // Every address reads back as itself XOR this key
    localparam lc3b_word MEM_KEY = 16'h5A3C;

    integer seed;
    integer wait_left;

    initial begin
        seed      = 60;
        wait_left = -1;
        wb_ack    = 1'b0;
        wb_dat_o  = 16'h0000;
    end

    // Ack comes 1 to 3 cycles into the request and outputs move 2 ns after the edge
    always begin
        @(posedge clk);
        #2;
        if (wb_ack) begin
            // Master closes the cycle on the ack edge
            wb_ack    = 1'b0;
            wait_left = -1;
        end else if (wb_cyc && wb_stb && !wb_we) begin
            if (wait_left < 0) begin
                wait_left = $unsigned($random(seed)) % 3;
            end
            if (wait_left == 0) begin
                wb_ack   = 1'b1;
                wb_dat_o = wb_adr ^ MEM_KEY;
            end else begin
                wait_left = wait_left - 1;
            end
        end else begin
            wait_left = -1;
        end
    end

endmodule : tb_wb_memory

//--- verilog/if_datapath.sv
`timescale 1ns/1ns

module if_datapath
    import lc3b_fetch_pkg::*;
(
    input  logic       clk,

    // Pipeline controls
    input  logic       br_en,
    input  logic       trap_en,
    input  logic       jmp_jsr_en,
    input  logic       b11,
    input  pcmux_sel_t pcmux_sel,
    input  lc3b_word   pc_br_in,
    input  lc3b_word   sr1_data_in,
    input  lc3b_word   trap_mem,
    input  logic       stall,
    input  logic       flush,

    // Wishbone master
    output logic       wb_cyc,
    output logic       wb_stb,
    output logic       wb_we,
    output lc3b_word   wb_adr,
    input  lc3b_word   wb_dat_i,
    input  logic       wb_ack,

    // To decode
    output lc3b_word   pc_out,
    output lc3b_word   instruction,
    output lc3b_reg    src1,
    output lc3b_reg    src2,
    output lc3b_reg    dest,

    // Counter
    input  logic       if_stall_count_reset,
    output lc3b_word   if_stall_count
);

    logic     resp;
    logic     take;
    logic     redirect;
    lc3b_word resp_word;

    pc_unit i_pc_unit (
        .clk                  (clk),
        .if_stall_count_reset (if_stall_count_reset),
        .take                 (take),
        .br_en                (br_en),
        .trap_en              (trap_en),
        .jmp_jsr_en           (jmp_jsr_en),
        .b11                  (b11),
        .pcmux_sel            (pcmux_sel),
        .pc_br_in             (pc_br_in),
        .sr1_data_in          (sr1_data_in),
        .trap_mem             (trap_mem),
        .resp_word            (resp_word),
        .pc_out               (pc_out),
        .redirect             (redirect)
    );

    wb_fetch_port i_wb_fetch_port (
        .clk                  (clk),
        .if_stall_count_reset (if_stall_count_reset),
        .stall                (stall),
        .redirect             (redirect),
        .wb_ack               (wb_ack),
        .pc_out               (pc_out),
        .wb_dat_i             (wb_dat_i),
        .wb_cyc               (wb_cyc),
        .wb_stb               (wb_stb),
        .wb_we                (wb_we),
        .wb_adr               (wb_adr),
        .resp                 (resp),
        .take                 (take),
        .resp_word            (resp_word)
    );

    ir_unit i_ir_unit (
        .clk                  (clk),
        .if_stall_count_reset (if_stall_count_reset),
        .take                 (take),
        .flush                (flush),
        .resp                 (resp),
        .stall                (stall),
        .resp_word            (resp_word),
        .instruction          (instruction),
        .src1                 (src1),
        .src2                 (src2),
        .dest                 (dest),
        .if_stall_count       (if_stall_count)
    );

endmodule : if_datapath

//--- verilog/ir_unit.sv
`timescale 1ns/1ns

module ir_unit
    import lc3b_fetch_pkg::*;
(
    input  logic     clk,
    input  logic     if_stall_count_reset,
    input  logic     take,
    input  logic     flush,
    input  logic     resp,
    input  logic     stall,
    input  lc3b_word resp_word,
    output lc3b_word instruction,
    output lc3b_reg  src1,
    output lc3b_reg  src2,
    output lc3b_reg  dest,
    output lc3b_word if_stall_count
);

    lc3b_instr ir_q;
    lc3b_word  count_q;
    logic      mem_wait;

    // ##################################################
    // Instruction register
    // ##################################################

    // Flush wins over a word taken in the same cycle
    always_ff @(posedge clk) begin
        if (if_stall_count_reset) begin
            ir_q.raw <= NOP_WORD;
        end else if (flush) begin
            ir_q.raw <= NOP_WORD;
        end else if (take) begin
            ir_q.raw <= resp_word;
        end
    end

    assign instruction = ir_q.raw;

    // Register fields straight from the stored word
    assign dest = ir_q.fields.dest;
    assign src1 = ir_q.fields.src1;
    assign src2 = ir_q.fields.src2;

    // ##################################################
    // Memory wait counter
    // ##################################################

    // No word ready and nothing holding the pipe, so fetch is waiting on memory
    assign mem_wait = ~resp & ~stall;

    always_ff @(posedge clk) begin
        if (if_stall_count_reset) begin
            count_q <= 16'h0000;
        end else if (mem_wait) begin
            // Wraps at 16 bits
            count_q <= count_q + 16'd1;
        end
    end

    assign if_stall_count = count_q;

endmodule : ir_unit

//--- verilog/lc3b_fetch_pkg.sv
package lc3b_fetch_pkg;

    // ##################################################
    // Basic words
    // ##################################################

    typedef logic [15:0] lc3b_word;
    typedef logic [2:0]  lc3b_reg;

    // ##################################################
    // Instruction views
    // ##################################################

    // Register form, as used by ADD/AND/NOT style encodings
    typedef struct packed {
        logic [3:0] opcode;
        lc3b_reg    dest;
        lc3b_reg    src1;
        logic       mode;
        logic [1:0] pad;
        lc3b_reg    src2;
    } lc3b_instr_fields;

    typedef union packed {
        lc3b_word         raw;
        lc3b_instr_fields fields;
    } lc3b_instr;

    // ##################################################
    // Next-PC sources
    // ##################################################

    typedef enum logic [2:0] {
        pc_plus2    = 3'd0,
        pc_branch   = 3'd1,
        pc_reg      = 3'd2,
        pc_mem_word = 3'd3,
        pc_trap     = 3'd4
    } pcmux_sel_t;

    // BR with nzp all clear, never taken
    localparam lc3b_word NOP_WORD = 16'h0000;

endpackage : lc3b_fetch_pkg

//--- verilog/pc_unit.sv
`timescale 1ns/1ns

module pc_unit
    import lc3b_fetch_pkg::*;
(
    input  logic       clk,
    input  logic       if_stall_count_reset,
    input  logic       take,
    input  logic       br_en,
    input  logic       trap_en,
    input  logic       jmp_jsr_en,
    input  logic       b11,
    input  pcmux_sel_t pcmux_sel,
    input  lc3b_word   pc_br_in,
    input  lc3b_word   sr1_data_in,
    input  lc3b_word   trap_mem,
    input  lc3b_word   resp_word,
    output lc3b_word   pc_out,
    output logic       redirect
);

    lc3b_word   pc_q;
    lc3b_word   pc_inc;
    lc3b_word   pc_next;
    pcmux_sel_t sel_int;
    logic       pc_load;

    // ##################################################
    // Source selection
    // ##################################################

    assign redirect = br_en | trap_en | jmp_jsr_en;
    assign pc_inc   = pc_q + 16'd2;

    // Branch beats trap beats JMP/JSR beats the decoder's own select
    always_comb begin
        if (br_en) begin
            sel_int = pc_branch;
        end else if (trap_en) begin
            sel_int = pc_trap;
        end else if (jmp_jsr_en) begin
            // JSR with b11 set uses the PC-relative target
            if (b11) begin
                sel_int = pc_branch;
            end else begin
                sel_int = pc_reg;
            end
        end else begin
            sel_int = pcmux_sel;
        end
    end

    always_comb begin
        case (sel_int)
            pc_plus2: begin
                pc_next = pc_inc;
            end
            pc_branch: begin
                pc_next = pc_br_in;
            end
            pc_reg: begin
                pc_next = sr1_data_in;
            end
            pc_mem_word: begin
                pc_next = resp_word;
            end
            pc_trap: begin
                pc_next = trap_mem;
            end
            default: begin
                pc_next = pc_inc;
            end
        endcase
    end

    // ##################################################
    // PC register
    // ##################################################

    // Redirects load even while stalled
    assign pc_load = redirect | take;

    always_ff @(posedge clk) begin
        if (if_stall_count_reset) begin
            pc_q <= 16'h0000;
        end else if (pc_load) begin
            pc_q <= pc_next;
        end
    end

    assign pc_out = pc_q;

endmodule : pc_unit

//--- verilog/wb_fetch_port.sv
`timescale 1ns/1ns

module wb_fetch_port
    import lc3b_fetch_pkg::*;
(
    input  logic     clk,
    input  logic     if_stall_count_reset,
    input  logic     stall,
    input  logic     redirect,
    input  logic     wb_ack,
    input  lc3b_word pc_out,
    input  lc3b_word wb_dat_i,
    output logic     wb_cyc,
    output logic     wb_stb,
    output logic     wb_we,
    output lc3b_word wb_adr,
    output logic     resp,
    output logic     take,
    output lc3b_word resp_word
);

    typedef enum logic [1:0] {
        st_idle = 2'd0,
        st_busy = 2'd1,
        st_full = 2'd2
    } port_state_t;

    port_state_t state_q;
    logic        stale_q;
    lc3b_word    adr_q;
    lc3b_word    buf_q;

    // Wrong-path words are never taken
    assign take = resp & ~stall & ~redirect;

    always_ff @(posedge clk) begin
        if (if_stall_count_reset) begin
            state_q <= st_idle;
            stale_q <= 1'b0;
        end else begin
            case (state_q)
                st_idle: begin
                    // Address is latched so it stays stable through the cycle
                    if (!stall && !redirect) begin
                        state_q <= st_busy;
                        adr_q   <= pc_out;
                    end
                end
                st_busy: begin
                    if (wb_ack) begin
                        stale_q <= 1'b0;
                        if (stale_q || redirect) begin
                            state_q <= st_idle;
                        end else begin
                            state_q <= st_full;
                            buf_q   <= wb_dat_i;
                        end
                    end else if (redirect) begin
                        stale_q <= 1'b1;
                    end
                end
                st_full: begin
                    if (redirect || take) begin
                        state_q <= st_idle;
                    end
                end
                default: begin
                    state_q <= st_idle;
                end
            endcase
        end
    end

    // Read only master with stb and cyc moving together
    assign wb_cyc    = (state_q == st_busy);
    assign wb_stb    = wb_cyc;
    assign wb_we     = 1'b0;
    assign wb_adr    = adr_q;
    assign resp      = (state_q == st_full);
    assign resp_word = buf_q;

endmodule : wb_fetch_port
